// ==== sdram_pkg.sv ====
/* SDRAM word, line and address types, payload types for the ROM slots,
   fetch slot count and slot indices */
package sdram_pkg;

    localparam int SDRAM_AW = 22;   // Word address bits
    localparam int SDRAM_DW = 16;   // One SDRAM word
    localparam int LINE_W   = 2 * SDRAM_DW; // A read returns two words

    // Word address into the SDRAM
    typedef logic [SDRAM_AW-1:0] sdram_addr_t;

    // Even word in the low half, odd word in the high half
    typedef logic [LINE_W-1:0] sdram_line_t;

    // Client payloads
    typedef logic [7:0]          byte_t;
    typedef logic [SDRAM_DW-1:0] half_t;

    localparam int SLOT_COUNT = 3;
    localparam int SLOT_IDX_W = $clog2(SLOT_COUNT);

    // Lower index wins arbitration
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_SND  = 1;
    localparam int SLOT_OBJ  = 2;

endpackage

// ==== rom_map_pkg.sv ====
/* ROM download memory map, SDRAM base of each fetch slot
   and client address widths */
package rom_map_pkg;

    // Byte offsets inside the download stream
    localparam logic [21:0] MAIN_LOAD = 22'h00000;
    localparam logic [21:0] SND_LOAD  = 22'h20000;
    localparam logic [21:0] OBJ_LOAD  = 22'h30000;
    localparam logic [21:0] PROM_LOAD = 22'h50000;  // Goes to on-chip PROM, not SDRAM

    // Object ROM is moved here in SDRAM (word address)
    localparam logic [21:0] OBJ_SDRAM = 22'h40000;

    // Word base seen by each slot
    localparam logic [21:0] MAIN_OFFSET = MAIN_LOAD >> 1;
    localparam logic [21:0] SND_OFFSET  = SND_LOAD >> 1;
    localparam logic [21:0] OBJ_OFFSET  = OBJ_SDRAM;

    localparam int MAIN_AW = 17;    // Byte address
    localparam int SND_AW  = 15;    // Byte address
    localparam int OBJ_AW  = 16;    // Word address
    localparam int PROM_AW = 8;

endpackage

// ==== rom_download.sv ====
/* ROM download mapper: byte stream to masked SDRAM writes,
   PROM region to single-cycle on-chip writes */
module rom_download (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              downloading,
    input  logic [sdram_pkg::SDRAM_AW-1:0]    ioctl_addr,
    input  sdram_pkg::byte_t                  ioctl_data,
    input  logic                              ioctl_wr,
    input  logic                              sdram_ack,
    output sdram_pkg::sdram_addr_t            prog_addr,
    output sdram_pkg::byte_t                  prog_data,
    output logic [1:0]                        prog_mask,
    output logic                              prog_we,
    output logic [rom_map_pkg::PROM_AW-1:0]   prom_addr,
    output sdram_pkg::byte_t                  prom_data,
    output logic                              prom_we
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    logic        wr_en;
    logic        in_prom;
    logic        in_obj;
    sdram_addr_t obj_rel;
    sdram_addr_t prom_rel;
    sdram_addr_t word_addr;

    assign wr_en   = downloading && ioctl_wr;
    assign in_prom = ioctl_addr >= PROM_LOAD;
    assign in_obj  = (ioctl_addr >= OBJ_LOAD) && !in_prom;

    assign obj_rel  = ioctl_addr - OBJ_LOAD;
    assign prom_rel = ioctl_addr - PROM_LOAD;

    // Object bytes are relocated, everything else maps one to one
    assign word_addr = in_obj ? OBJ_SDRAM + (obj_rel >> 1) : ioctl_addr >> 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_en && in_prom;    // Single cycle
            if (wr_en && !in_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;            // Released after the controller takes it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !in_prom) begin
            prog_addr <= word_addr;
            prog_data <= ioctl_data;
            // Mask bit set = byte lane not written
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
        if (wr_en && in_prom) begin
            prom_addr <= prom_rel[PROM_AW-1:0];
            prom_data <= ioctl_data;
        end
    end

endmodule

// ==== rom_slot.sv ====
/* One ROM fetch client: single-line cache with tag, payload select
   and refill request toward the arbiter */
module rom_slot #(
    parameter type                    data_t = sdram_pkg::byte_t,
    parameter int                     AW     = 17,
    parameter sdram_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cs,
    input  logic [AW-1:0]           addr,
    output data_t                   data,
    output logic                    ok,
    output logic                    req,
    output sdram_pkg::sdram_addr_t  req_addr,
    input  logic                    fill,
    input  sdram_pkg::sdram_line_t  fill_data
);
    import sdram_pkg::*;

    localparam int DW    = $bits(data_t);
    localparam int SHIFT = (DW == 8) ? 1 : 0;   // Byte clients address bytes
    localparam int SEL_W = (DW == 8) ? 2 : 1;   // Items per line: 4 bytes or 2 words

    sdram_addr_t         word_addr;
    logic [SDRAM_AW-2:0] line_tag;
    logic                line_valid;
    sdram_line_t         line_data;
    logic [SEL_W-1:0]    sel;
    logic                hit;
    logic                miss;

    assign word_addr = OFFSET + (sdram_addr_t'(addr) >> SHIFT);

    // Item position inside the 32-bit line, little-endian
    if (DW == 8) begin : g_byte
        assign sel = {word_addr[0], addr[0]};
    end else begin : g_half
        assign sel = word_addr[0];
    end

    assign hit  = line_valid && (line_tag == word_addr[SDRAM_AW-1:1]);
    assign miss = cs && !hit && !req;

    assign ok   = cs && hit;
    assign data = line_data[sel*DW +: DW];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req        <= 1'b0;
            line_valid <= 1'b0;
        end else if (fill) begin
            req        <= 1'b0;
            line_valid <= 1'b1;
        end else if (miss) begin
            req <= 1'b1;    // Held until the arbiter fills us
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            req_addr <= {word_addr[SDRAM_AW-1:1], 1'b0};   // Even word starts the line
        end
        if (fill) begin
            line_data <= fill_data;
            // Tag follows the requested line, not the current address
            line_tag  <= req_addr[SDRAM_AW-1:1];
        end
    end

endmodule

// ==== rom_arbiter.sv ====
/* Fixed-priority arbiter for slot refills, one SDRAM read in flight,
   returned line routed to the granted slot */
module rom_arbiter (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    downloading,
    input  logic [sdram_pkg::SLOT_COUNT-1:0]        slot_req,
    input  sdram_pkg::sdram_addr_t                  slot_addr [sdram_pkg::SLOT_COUNT],
    output logic [sdram_pkg::SLOT_COUNT-1:0]        slot_fill,
    output sdram_pkg::sdram_line_t                  fill_data,
    output logic                                    sdram_req,
    output sdram_pkg::sdram_addr_t                  sdram_addr,
    input  logic                                    sdram_ack,
    input  logic                                    data_rdy,
    input  sdram_pkg::sdram_line_t                  data_read
);
    import sdram_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,     // sdram_req up, waiting for ack
        ST_WAIT     // Ack seen, waiting for data_rdy
    } state_t;

    state_t                state;
    logic [SLOT_COUNT-1:0] pending;
    logic [SLOT_IDX_W-1:0] pick;
    logic [SLOT_IDX_W-1:0] grant;
    logic                  pick_valid;
    logic                  grant_now;

    // A slot being filled this cycle still shows its request
    assign pending = slot_req & ~slot_fill;

    always_comb begin
        pick       = '0;
        pick_valid = 1'b0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick       = SLOT_IDX_W'(i);    // Lowest index ends up here
                pick_valid = 1'b1;
            end
        end
    end

    // No reads while the download owns the SDRAM
    assign grant_now = (state == ST_IDLE) && pick_valid && !downloading;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            slot_fill <= '0;
            grant     <= '0;
        end else begin
            slot_fill <= '0;
            case (state)
                ST_IDLE: begin
                    if (grant_now) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin
                        slot_fill[grant] <= 1'b1;
                        state            <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_now) begin
            sdram_addr <= slot_addr[pick];
        end
        if (state == ST_WAIT && data_rdy) begin
            fill_data <= data_read;
        end
    end

endmodule

// ==== rom_system.sv ====
/* ROM path top level: download mapper, refill arbiter
   and the main, sound and object fetch slots */
module rom_system (
    input  logic                                clk,
    input  logic                                rst_n,
    // Download
    input  logic                                downloading,
    input  logic [sdram_pkg::SDRAM_AW-1:0]      ioctl_addr,
    input  sdram_pkg::byte_t                    ioctl_data,
    input  logic                                ioctl_wr,
    output sdram_pkg::sdram_addr_t              prog_addr,
    output sdram_pkg::byte_t                    prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we,
    output logic                                prom_we,
    output logic [rom_map_pkg::PROM_AW-1:0]     prom_addr,
    output sdram_pkg::byte_t                    prom_data,
    // SDRAM read port
    output logic                                sdram_req,
    output sdram_pkg::sdram_addr_t              sdram_addr,
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    input  sdram_pkg::sdram_line_t              data_read,
    // Main CPU
    input  logic                                main_cs,
    input  logic [rom_map_pkg::MAIN_AW-1:0]     main_addr,
    output sdram_pkg::byte_t                    main_data,
    output logic                                main_ok,
    // Sound CPU
    input  logic                                snd_cs,
    input  logic [rom_map_pkg::SND_AW-1:0]      snd_addr,
    output sdram_pkg::byte_t                    snd_data,
    output logic                                snd_ok,
    // Objects
    input  logic                                obj_cs,
    input  logic [rom_map_pkg::OBJ_AW-1:0]      obj_addr,
    output sdram_pkg::half_t                    obj_data,
    output logic                                obj_ok
);
    import sdram_pkg::*;
    import rom_map_pkg::*;

    logic [SLOT_COUNT-1:0] slot_req;
    logic [SLOT_COUNT-1:0] slot_fill;
    sdram_addr_t           slot_addr [SLOT_COUNT];
    sdram_line_t           fill_data;

    rom_download u_download (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_data  ( ioctl_data   ),
        .ioctl_wr    ( ioctl_wr     ),
        .sdram_ack   ( sdram_ack    ),
        .prog_addr   ( prog_addr    ),
        .prog_data   ( prog_data    ),
        .prog_mask   ( prog_mask    ),
        .prog_we     ( prog_we      ),
        .prom_addr   ( prom_addr    ),
        .prom_data   ( prom_data    ),
        .prom_we     ( prom_we      )
    );

    rom_arbiter u_arbiter (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .slot_req    ( slot_req     ),
        .slot_addr   ( slot_addr    ),
        .slot_fill   ( slot_fill    ),
        .fill_data   ( fill_data    ),
        .sdram_req   ( sdram_req    ),
        .sdram_addr  ( sdram_addr   ),
        .sdram_ack   ( sdram_ack    ),
        .data_rdy    ( data_rdy     ),
        .data_read   ( data_read    )
    );

    rom_slot #(
        .data_t ( byte_t       ),
        .AW     ( MAIN_AW      ),
        .OFFSET ( MAIN_OFFSET  )
    ) u_main_slot (
        .clk       ( clk                  ),
        .rst_n     ( rst_n                ),
        .cs        ( main_cs              ),
        .addr      ( main_addr            ),
        .data      ( main_data            ),
        .ok        ( main_ok              ),
        .req       ( slot_req[SLOT_MAIN]  ),
        .req_addr  ( slot_addr[SLOT_MAIN] ),
        .fill      ( slot_fill[SLOT_MAIN] ),
        .fill_data ( fill_data            )
    );

    rom_slot #(
        .data_t ( byte_t       ),
        .AW     ( SND_AW       ),
        .OFFSET ( SND_OFFSET   )
    ) u_snd_slot (
        .clk       ( clk                  ),
        .rst_n     ( rst_n                ),
        .cs        ( snd_cs               ),
        .addr      ( snd_addr             ),
        .data      ( snd_data             ),
        .ok        ( snd_ok               ),
        .req       ( slot_req[SLOT_SND]   ),
        .req_addr  ( slot_addr[SLOT_SND]  ),
        .fill      ( slot_fill[SLOT_SND]  ),
        .fill_data ( fill_data            )
    );

    // Object ROM is addressed in words
    rom_slot #(
        .data_t ( half_t       ),
        .AW     ( OBJ_AW       ),
        .OFFSET ( OBJ_OFFSET   )
    ) u_obj_slot (
        .clk       ( clk                  ),
        .rst_n     ( rst_n                ),
        .cs        ( obj_cs               ),
        .addr      ( obj_addr             ),
        .data      ( obj_data             ),
        .ok        ( obj_ok               ),
        .req       ( slot_req[SLOT_OBJ]   ),
        .req_addr  ( slot_addr[SLOT_OBJ]  ),
        .fill      ( slot_fill[SLOT_OBJ]  ),
        .fill_data ( fill_data            )
    );

endmodule

// ==== rom_system_checker.sv ====
/* Bound protocol assertions for the ROM path top level */
module rom_system_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             sdram_req,
    input logic             sdram_ack,
    input logic             prog_we,
    input logic             prom_we,
    input logic             main_cs,
    input logic             main_ok,
    input sdram_pkg::byte_t main_data,
    input logic             snd_cs,
    input logic             snd_ok,
    input sdram_pkg::byte_t snd_data,
    input logic             obj_cs,
    input logic             obj_ok,
    input sdram_pkg::half_t obj_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Read request stays up until the controller takes it
    req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin
            fail_count++;
            $error("sdram_req dropped before sdram_ack");
        end

    // Download writes and slot reads share the SDRAM port
    port_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && sdram_req))
        else begin
            fail_count++;
            $error("prog_we and sdram_req high together");
        end

    prom_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |=> !prom_we)
        else begin
            fail_count++;
            $error("prom_we longer than one cycle");
        end

    // Data is valid whenever ok is up
    main_ok_a: assert property (@(posedge clk) disable iff (!rst_n)
        main_ok |-> main_cs && !$isunknown(main_data))
        else begin
            fail_count++;
            $error("main_ok without main_cs or with unknown main_data");
        end

    snd_ok_a: assert property (@(posedge clk) disable iff (!rst_n)
        snd_ok |-> snd_cs && !$isunknown(snd_data))
        else begin
            fail_count++;
            $error("snd_ok without snd_cs or with unknown snd_data");
        end

    obj_ok_a: assert property (@(posedge clk) disable iff (!rst_n)
        obj_ok |-> obj_cs && !$isunknown(obj_data))
        else begin
            fail_count++;
            $error("obj_ok without obj_cs or with unknown obj_data");
        end

endmodule

// ==== tb_rom_system.sv ====
/* ROM path testbench with directed download and fetch tests, an SDRAM model
   with random delays, clock, reset and timeout */
module tb_rom_system;
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_pkg::*;
    import rom_map_pkg::*;

    localparam int TEST_COUNT  = 6;
    localparam int TEST_BUDGET = 1000;  // Cycles per test with margin
    localparam int TIMEOUT     = TEST_COUNT * TEST_BUDGET;
    localparam int WAIT_LIMIT  = 100;

    logic clk, rst_n, downloading, ioctl_wr;
    logic [21:0] ioctl_addr;
    byte_t ioctl_data, prog_data, prom_data, main_data, snd_data;
    sdram_addr_t prog_addr, sdram_addr;
    logic [1:0] prog_mask;
    logic prog_we, prom_we, sdram_req, sdram_ack, data_rdy;
    logic [PROM_AW-1:0] prom_addr;
    sdram_line_t data_read;
    logic main_cs, snd_cs, obj_cs, main_ok, snd_ok, obj_ok;
    logic [MAIN_AW-1:0] main_addr;
    logic [SND_AW-1:0] snd_addr;
    logic [OBJ_AW-1:0] obj_addr;
    half_t obj_data;

    logic [15:0] mem [int];         // SDRAM words
    logic [7:0] dl_bytes [int];     // Reference copy by download address
    sdram_addr_t read_log [$];
    logic [31:0] rng = 32'd22;
    int cycles = 0, errors = 0, tests_run = 0, tests_failed = 0;
    int ack_wait = 0, rdy_wait = 0;
    sdram_addr_t rd_addr;
    string test_name;

    rom_system dut_i (.*);
    bind rom_system rom_system_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] word_at(sdram_addr_t a);
        return mem.exists(a) ? mem[a] : 16'h0000;
    endfunction

    // SDRAM model with acks and data after 1 to 4 cycles
    always @(negedge clk) begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        if (!rst_n) begin
            ack_wait = 0;
            rdy_wait = 0;
        end else if (rdy_wait > 0) begin
            rdy_wait--;
            if (rdy_wait == 0) begin
                data_read = {word_at(rd_addr | 22'h1), word_at(rd_addr & ~22'h1)};
                data_rdy  = 1'b1;
            end
        end else if (prog_we || sdram_req) begin
            if (ack_wait == 0)
                ack_wait = 1 + int'(next_rand() % 4);
            ack_wait--;
            if (ack_wait == 0) begin
                sdram_ack = 1'b1;
                if (prog_we) begin
                    mem[prog_addr] = word_at(prog_addr);
                    if (!prog_mask[0]) mem[prog_addr][7:0] = prog_data;
                    if (!prog_mask[1]) mem[prog_addr][15:8] = prog_data;
                end else begin
                    rd_addr = sdram_addr;
                    read_log.push_back(sdram_addr);
                    rdy_wait = 1 + int'(next_rand() % 4);
                end
            end
        end
    end

    task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    function automatic logic [21:0] expected_word(logic [21:0] a);
        if (a >= OBJ_LOAD && a < PROM_LOAD)
            return OBJ_SDRAM + ((a - OBJ_LOAD) >> 1);
        return a >> 1;
    endfunction

    function automatic logic [15:0] expected_item(int slot, logic [21:0] a);
        case (slot)
            0: return {8'h00, dl_bytes[MAIN_LOAD + a]};
            1: return {8'h00, dl_bytes[SND_LOAD + a]};
            default: return {dl_bytes[OBJ_LOAD + 2 * a + 1], dl_bytes[OBJ_LOAD + 2 * a]};
        endcase
    endfunction

    task automatic download_byte(logic [21:0] a, logic [7:0] d);
        int n = 0;
        @(negedge clk);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        dl_bytes[a] = d;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (a >= PROM_LOAD) begin
            compare("prom_we", 1, prom_we);
            compare("prom_addr", (a - PROM_LOAD) & 22'hff, prom_addr);
            compare("prom_data", d, prom_data);
            compare("prog_we", 0, prog_we);
            @(negedge clk);
            compare("prom_we after", 0, prom_we);
            compare("prog_we after", 0, prog_we);
        end else begin
            compare("prog_we", 1, prog_we);
            compare("prog_addr", expected_word(a), prog_addr);
            compare("prog_mask", a[0] ? 2'b01 : 2'b10, prog_mask);
            compare("prog_data", d, prog_data);
            while (prog_we && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (prog_we) begin
                errors++;
                $display("%s: SDRAM write was never released", test_name);
            end
        end
    endtask

    task automatic drive_slot(int slot, logic cs, logic [21:0] a);
        case (slot)
            0: begin
                main_cs   = cs;
                main_addr = a[MAIN_AW-1:0];
            end
            1: begin
                snd_cs   = cs;
                snd_addr = a[SND_AW-1:0];
            end
            default: begin
                obj_cs   = cs;
                obj_addr = a[OBJ_AW-1:0];
            end
        endcase
    endtask

    task automatic sample_slot(int slot, output logic ok, output logic [15:0] data);
        case (slot)
            0: begin
                ok   = main_ok;
                data = {8'h00, main_data};
            end
            1: begin
                ok   = snd_ok;
                data = {8'h00, snd_data};
            end
            default: begin
                ok   = obj_ok;
                data = obj_data;
            end
        endcase
    endtask

    // Fetch one item and check for a hit without an SDRAM read when expect_hit is set
    task automatic read_slot(int slot, logic [21:0] a, bit expect_hit);
        logic ok;
        logic [15:0] data;
        logic req_seen = 1'b0;
        int n = 0;
        @(negedge clk);
        drive_slot(slot, 1'b1, a);
        #1 sample_slot(slot, ok, data);
        if (expect_hit)
            compare("hit ok", 1, ok);
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1 sample_slot(slot, ok, data);
            n++;
        end
        if (!ok) begin
            errors++;
            $display("%s: slot %0d never returned ok", test_name, slot);
        end else begin
            compare("read data", expected_item(slot, a), data);
        end
        @(negedge clk);
        drive_slot(slot, 1'b0, a);
        if (expect_hit) begin
            // A false miss shows on sdram_req two edges after cs
            repeat (3) begin
                @(negedge clk);
                req_seen = req_seen | sdram_req;
            end
            compare("sdram_req on hit", 0, req_seen);
        end
    endtask

    task automatic end_test(int errors_before);
        tests_run++;
        if (errors != errors_before)
            tests_failed++;
        $display("%s finished with %0d errors", test_name, errors - errors_before);
    endtask

    task automatic test_reset();
        int e = errors;
        test_name = "reset";
        compare("sdram_req", 0, sdram_req);
        compare("prog_we", 0, prog_we);
        compare("prom_we", 0, prom_we);
        compare("ok", 3'b000, {main_ok, snd_ok, obj_ok});
        end_test(e);
    endtask

    task automatic test_map();
        int e = errors;
        test_name = "download_map";
        downloading = 1'b1;
        download_byte(22'h00011, 8'h5a);
        download_byte(22'h00012, 8'ha5);
        download_byte(22'h20005, 8'h33);
        download_byte(22'h30000, 8'h71);
        download_byte(22'h30003, 8'h17);
        download_byte(22'h4ffff, 8'hee);
        end_test(e);
    endtask

    task automatic test_prom();
        int e = errors;
        test_name = "prom_write";
        download_byte(22'h50010, 8'h3c);
        download_byte(22'h50123, 8'hc3);
        end_test(e);
    endtask

    task automatic test_cpu_read();
        int e = errors;
        test_name = "cpu_read";
        for (int i = 0; i < 16; i++) begin
            download_byte(MAIN_LOAD + 22'h100 + i, next_rand());
            download_byte(SND_LOAD + 22'h40 + i, next_rand());
        end
        downloading = 1'b0;
        read_slot(0, 22'h100, 1'b0);
        read_slot(0, 22'h103, 1'b1);   // Same line
        read_slot(1, 22'h40, 1'b0);
        read_slot(1, 22'h41, 1'b1);
        end_test(e);
    endtask

    task automatic test_obj_read();
        int e = errors;
        test_name = "obj_read";
        downloading = 1'b1;
        for (int i = 0; i < 16; i++)
            download_byte(OBJ_LOAD + 22'h20 + i, next_rand());
        downloading = 1'b0;
        read_slot(2, 22'h10, 1'b0);
        read_slot(2, 22'h11, 1'b1);
        end_test(e);
    endtask

    task automatic test_contention();
        logic ok;
        logic [15:0] data;
        logic [21:0] addrs [3] = '{22'h108, 22'h48, 22'h14};
        bit done [3] = '{0, 0, 0};
        int n = 0;
        int first = read_log.size();
        int e = errors;
        test_name = "contention";
        @(negedge clk);
        for (int s = 0; s < 3; s++)
            drive_slot(s, 1'b1, addrs[s]);
        while (!(done[0] && done[1] && done[2]) && n < 3 * WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            for (int s = 0; s < 3; s++) begin
                sample_slot(s, ok, data);
                if (ok && !done[s]) begin
                    done[s] = 1'b1;
                    compare($sformatf("slot %0d data", s), expected_item(s, addrs[s]), data);
                end
            end
            n++;
        end
        if (!(done[0] && done[1] && done[2])) begin
            errors++;
            $display("%s: not every slot got its line", test_name);
        end
        if (read_log.size() > first)
            compare("first sdram_addr", (MAIN_LOAD + 22'h108) >> 1, read_log[first]);
        @(negedge clk);
        for (int s = 0; s < 3; s++)
            drive_slot(s, 1'b0, addrs[s]);
        end_test(e);
    endtask

    initial begin
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        sdram_ack = 1'b0;
        data_rdy = 1'b0;
        data_read = '0;
        main_cs = 1'b0;
        main_addr = '0;
        snd_cs = 1'b0;
        snd_addr = '0;
        obj_cs = 1'b0;
        obj_addr = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_map();
        test_prom();
        test_cpu_read();
        test_obj_read();
        test_contention();
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut_i.checker_i.fail_count);
        if (errors == 0 && dut_i.checker_i.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== compile.f ====
sdram_pkg.sv
rom_map_pkg.sv
rom_download.sv
rom_slot.sv
rom_arbiter.sv
rom_system.sv
rom_system_checker.sv
tb_rom_system.sv
